// ==== compile.f ====
hdl/dcache_pkg.sv
hdl/dcache_tag_array.sv
hdl/dcache_data_array.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
test/tb_mem_model.sv
test/tb_dcache.sv

// ==== test/tb_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dcache
	import dcache_pkg::*;
();

	typedef struct packed {
		logic     wr;
		addr_t    addr;
		word_t    data;
		byte_en_t mask;
		logic     hit;
		int       reads;
		int       writes;
	} row_t;

	logic     clk;
	logic     rst;
	logic     valid;
	addr_t    addr;
	logic     wren;
	word_t    din;
	byte_en_t mask;
	logic     ready;
	word_t    dout;
	logic     mem_req;
	logic     mem_we;
	addr_t    mem_addr;
	word_t    mem_wdata;
	byte_en_t mem_wmask;
	logic     mem_ack;
	line_t    mem_rdata;
	int       read_count;
	int       write_count;

	row_t  rows [$];
	word_t ref_mem [addr_t];
	int    errors = 0;
	int    exp_reads = 0;
	int    exp_writes = 0;
	int    cycles = 0;
	int    cycle_limit = 1000;

	dcache_top #(
		.uncached_base (32'h9000_0000)
	) i_dut (
		.clk       (clk),
		.rst       (rst),
		.valid     (valid),
		.addr      (addr),
		.wren      (wren),
		.din       (din),
		.mask      (mask),
		.ready     (ready),
		.dout      (dout),
		.mem_req   (mem_req),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_wmask (mem_wmask),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata)
	);

	tb_mem_model i_mem (
		.clk         (clk),
		.rst         (rst),
		.mem_req     (mem_req),
		.mem_we      (mem_we),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.mem_wmask   (mem_wmask),
		.mem_ack     (mem_ack),
		.mem_rdata   (mem_rdata),
		.read_count  (read_count),
		.write_count (write_count)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("ERROR: run stopped after %0d cycles before all rows finished", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	// memory starts with the word address in the upper half and its inverse below
	function automatic word_t rule_word(input addr_t a);
		logic [31:0] waddr;
		waddr = {3'b000, a[31:3]};
		return {waddr, ~waddr};
	endfunction

	function automatic word_t ref_read(input addr_t a);
		addr_t key;
		key = {a[31:3], 3'b000};
		return ref_mem.exists(key) ? ref_mem[key] : rule_word(key);
	endfunction

	task automatic ref_write(input addr_t a, input word_t d, input byte_en_t m);
		word_t w;
		w = ref_read(a);
		for (int b = 0; b < 8; b++) begin
			if (m[b]) begin
				w[b*8 +: 8] = d[b*8 +: 8];
			end
		end
		ref_mem[{a[31:3], 3'b000}] = w;
	endtask

	task automatic check_word(input string name, input word_t got, input word_t want);
		if (got !== want) begin
			$display("FAILED at %0t: %s expected %h got %h", $time, name, want, got);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int want);
		if (got != want) begin
			$display("FAILED at %0t: %s expected %0d got %0d", $time, name, want, got);
			errors++;
		end
	endtask

	task automatic check_quiet(input string when);
		if (ready !== 1'b0) begin
			$display("FAILED at %0t: ready %s expected 0 got %b", $time, when, ready);
			errors++;
		end
		if (mem_req !== 1'b0) begin
			$display("FAILED at %0t: mem_req %s expected 0 got %b", $time, when, mem_req);
			errors++;
		end
	endtask

	task automatic add_row(input logic wr, input addr_t a, input word_t d, input byte_en_t m,
			input logic hit, input int reads, input int writes);
		row_t r;
		r = '{wr: wr, addr: a, data: d, mask: m, hit: hit, reads: reads, writes: writes};
		rows.push_back(r);
	endtask

	task automatic build_table();
		// miss, then hits on both words of the line
		add_row(0, 32'h0000_1000, '0, '0, 0, 1, 0);
		add_row(0, 32'h0000_1000, '0, '0, 1, 0, 0);
		add_row(0, 32'h0000_1008, '0, '0, 1, 0, 0);
		// write hits merge into the cached line and still go through
		add_row(1, 32'h0000_1008, 64'h1122_3344_5566_7788, 8'h0f, 0, 0, 1);
		add_row(0, 32'h0000_1008, '0, '0, 1, 0, 0);
		add_row(1, 32'h0000_1000, 64'ha5a5_0000_0000_5a5a, 8'h81, 0, 0, 1);
		add_row(0, 32'h0000_1000, '0, '0, 1, 0, 0);
		// write miss does not allocate
		add_row(1, 32'h0000_2010, 64'hcafe_f00d_dead_beef, 8'hf0, 0, 0, 1);
		add_row(0, 32'h0000_2010, '0, '0, 0, 1, 0);
		add_row(0, 32'h0000_2018, '0, '0, 1, 0, 0);
		// five lines map to set 3 and the fifth evicts way 0
		add_row(0, 32'h0000_4030, '0, '0, 0, 1, 0);
		add_row(0, 32'h0000_4430, '0, '0, 0, 1, 0);
		add_row(0, 32'h0000_4830, '0, '0, 0, 1, 0);
		add_row(0, 32'h0000_4c30, '0, '0, 0, 1, 0);
		add_row(0, 32'h0000_5030, '0, '0, 0, 1, 0);
		add_row(0, 32'h0000_4430, '0, '0, 1, 0, 0);
		add_row(0, 32'h0000_4030, '0, '0, 0, 1, 0);
		// uncached region never hits
		add_row(0, 32'h9000_0000, '0, '0, 0, 1, 0);
		add_row(0, 32'h9000_0000, '0, '0, 0, 1, 0);
		add_row(1, 32'h9000_0008, 64'h0123_4567_89ab_cdef, 8'hff, 0, 0, 1);
		add_row(0, 32'h9000_0008, '0, '0, 0, 1, 0);
		add_row(0, 32'h8fff_fff8, '0, '0, 0, 1, 0);
		add_row(0, 32'h8fff_fff8, '0, '0, 1, 0, 0);
	endtask

	task automatic run_row(input int n);
		row_t r;
		int   waited;
		int   errors_before;
		r = rows[n];
		errors_before = errors;
		@(negedge clk);
		valid = 1'b1;
		wren = r.wr;
		addr = r.addr;
		din = r.data;
		mask = r.mask;
		if (r.wr) begin
			ref_write(r.addr, r.data, r.mask);
		end
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (ready !== 1'b1);
		if (!r.wr) begin
			check_word("dout", dout, ref_read(r.addr));
		end
		valid = 1'b0;
		if (r.hit && waited != 2) begin
			$display("ERROR: hit at %h took %0d cycles instead of 2", r.addr, waited);
			errors++;
		end
		exp_reads += r.reads;
		exp_writes += r.writes;
		check_count("read_count", read_count, exp_reads);
		check_count("write_count", write_count, exp_writes);
		$display("row %0d: %s %h in %0d cycles, %s", n, r.wr ? "write" : "read",
			r.addr, waited, (errors == errors_before) ? "ok" : "mismatch");
	endtask

	initial begin
		rst = 1'b1;
		valid = 1'b0;
		wren = 1'b0;
		addr = '0;
		din = '0;
		mask = '0;
		build_table();
		cycle_limit = rows.size() * 40 + 100;
		repeat (4) begin
			@(negedge clk);
			check_quiet("during reset");
		end
		rst = 1'b0;
		@(negedge clk);
		check_quiet("after reset");
		for (int n = 0; n < rows.size(); n++) begin
			run_row(n);
		end
		$display("summary: %0d rows, %0d errors, %0d memory reads, %0d memory writes",
			rows.size(), errors, read_count, write_count);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/tb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model
	import dcache_pkg::*;
(
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire logic     mem_req,
	input  wire logic     mem_we,
	input  wire addr_t    mem_addr,
	input  wire word_t    mem_wdata,
	input  wire byte_en_t mem_wmask,
	output logic          mem_ack,
	output line_t         mem_rdata,
	output int            read_count,
	output int            write_count
);

	// only words that were written are stored, the rest follow the fill rule
	word_t       stored [addr_t];
	logic [31:0] lfsr;
	int          delay_left;
	logic        pending;

	function automatic word_t initial_word(input addr_t a);
		logic [31:0] waddr;
		waddr = {3'b000, a[31:3]};
		return {waddr, ~waddr};
	endfunction

	function automatic word_t fetch_word(input addr_t a);
		addr_t key;
		key = {a[31:3], 3'b000};
		return stored.exists(key) ? stored[key] : initial_word(key);
	endfunction

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// two bits from the lfsr give an ack delay of 0 to 3 cycles
	task automatic draw_delay(output int d);
		logic [1:0] bits;
		bits[0] = lfsr[0];
		lfsr = lfsr_next(lfsr);
		bits[1] = lfsr[0];
		lfsr = lfsr_next(lfsr);
		d = bits;
	endtask

	task automatic answer_request();
		word_t w;
		if (mem_we) begin
			w = fetch_word(mem_addr);
			for (int b = 0; b < 8; b++) begin
				if (mem_wmask[b]) begin
					w[b*8 +: 8] = mem_wdata[b*8 +: 8];
				end
			end
			stored[{mem_addr[31:3], 3'b000}] = w;
			write_count++;
		end else begin
			mem_rdata = {fetch_word(mem_addr + 32'd8), fetch_word(mem_addr)};
			read_count++;
		end
		mem_ack = 1'b1;
	endtask

	initial begin
		mem_ack = 1'b0;
		mem_rdata = '0;
		read_count = 0;
		write_count = 0;
		pending = 1'b0;
		delay_left = 0;
		lfsr = 32'haf6c;
	end

	// the model runs on the falling edge so the DUT sees stable ack and data
	always @(negedge clk) begin
		if (rst) begin
			mem_ack = 1'b0;
			pending = 1'b0;
		end else if (mem_ack) begin
			// ack follows req back down to finish the four-phase handshake
			if (!mem_req) begin
				mem_ack = 1'b0;
			end
		end else if (mem_req) begin
			if (!pending) begin
				pending = 1'b1;
				draw_delay(delay_left);
			end
			if (delay_left == 0) begin
				answer_request();
				pending = 1'b0;
			end else begin
				delay_left--;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top
	import dcache_pkg::*;
#(
	parameter addr_t uncached_base = 32'h9000_0000
) (
	input  wire logic     clk,
	input  wire logic     rst,

	input  wire logic     valid,
	input  wire addr_t    addr,
	input  wire logic     wren,
	input  wire word_t    din,
	input  wire byte_en_t mask,
	output wire logic     ready,
	output wire word_t    dout,

	output wire logic     mem_req,
	output wire logic     mem_we,
	output wire addr_t    mem_addr,
	output wire word_t    mem_wdata,
	output wire byte_en_t mem_wmask,
	input  wire logic     mem_ack,
	input  wire line_t    mem_rdata
);

	wire index_t      arr_index;
	wire tag_t        arr_tag;
	wire logic        arr_fill;
	wire logic        arr_wr;
	wire way_t        arr_way;
	wire line_t       arr_line;
	wire word_t       arr_word;
	wire logic        arr_wr_hi;
	wire byte_en_t    arr_wr_mask;
	wire way_t        way_hit;
	wire way_t        victim;
	wire line_t [3:0] rd_lines;

	// tags and data are looked up in parallel from the same registered index
	dcache_tag_array i_tag_array (
		.clk      (clk),
		.rst      (rst),
		.index    (arr_index),
		.tag      (arr_tag),
		.fill     (arr_fill),
		.fill_way (arr_way),
		.way_hit  (way_hit),
		.victim   (victim)
	);

	dcache_data_array i_data_array (
		.clk       (clk),
		.index     (arr_index),
		.fill      (arr_fill),
		.wr        (arr_wr),
		.way       (arr_way),
		.fill_line (arr_line),
		.wr_word   (arr_word),
		.wr_hi     (arr_wr_hi),
		.wr_mask   (arr_wr_mask),
		.rd_lines  (rd_lines)
	);

	dcache_ctrl #(
		.uncached_base (uncached_base)
	) i_ctrl (
		.clk         (clk),
		.rst         (rst),
		.valid       (valid),
		.addr        (addr),
		.wren        (wren),
		.din         (din),
		.mask        (mask),
		.ready       (ready),
		.dout        (dout),
		.mem_req     (mem_req),
		.mem_we      (mem_we),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.mem_wmask   (mem_wmask),
		.mem_ack     (mem_ack),
		.mem_rdata   (mem_rdata),
		.arr_index   (arr_index),
		.arr_tag     (arr_tag),
		.arr_fill    (arr_fill),
		.arr_wr      (arr_wr),
		.arr_way     (arr_way),
		.arr_line    (arr_line),
		.arr_word    (arr_word),
		.arr_wr_hi   (arr_wr_hi),
		.arr_wr_mask (arr_wr_mask),
		.way_hit     (way_hit),
		.victim      (victim),
		.rd_lines    (rd_lines)
	);

endmodule

`default_nettype wire

// ==== hdl/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
	import dcache_pkg::*;
#(
	parameter addr_t uncached_base = 32'h9000_0000
) (
	input  wire logic     clk,
	input  wire logic     rst,

	// processor side
	input  wire logic     valid,
	input  wire addr_t    addr,
	input  wire logic     wren,
	input  wire word_t    din,
	input  wire byte_en_t mask,
	output logic          ready,
	output word_t         dout,

	// memory side
	output logic          mem_req,
	output logic          mem_we,
	output addr_t         mem_addr,
	output word_t         mem_wdata,
	output byte_en_t      mem_wmask,
	input  wire logic     mem_ack,
	input  wire line_t    mem_rdata,

	// tag and data arrays
	output index_t        arr_index,
	output tag_t          arr_tag,
	output logic          arr_fill,
	output logic          arr_wr,
	output way_t          arr_way,
	output line_t         arr_line,
	output word_t         arr_word,
	output logic          arr_wr_hi,
	output byte_en_t      arr_wr_mask,
	input  wire way_t     way_hit,
	input  wire way_t     victim,
	input  wire line_t [3:0] rd_lines
);

	ctrl_state_t state;
	ctrl_state_t state_next;

	// request held for the whole transaction
	addr_t    req_addr;
	logic     req_wren;
	word_t    req_din;
	byte_en_t req_mask;
	logic     req_cached;

	way_t  hit_way_q;
	logic  from_mem_q;
	line_t line_q;

	logic  hit;
	line_t hit_line;
	line_t line_sel;

	assign hit = req_cached && (|way_hit);

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (valid) begin
					state_next = st_lookup;
				end
			end
			st_lookup: begin
				// writes always go through, read misses and uncached reads fetch a line
				if (req_wren) begin
					state_next = st_wr_req;
				end else if (hit) begin
					state_next = st_done;
				end else begin
					state_next = st_fill_req;
				end
			end
			st_fill_req: begin
				// the previous transaction's ack has to be gone first
				if (!mem_ack) begin
					state_next = st_fill_wait;
				end
			end
			st_fill_wait: begin
				if (mem_ack) begin
					state_next = st_done;
				end
			end
			st_wr_req: begin
				if (!mem_ack) begin
					state_next = st_wr_wait;
				end
			end
			st_wr_wait: begin
				if (mem_ack) begin
					state_next = st_done;
				end
			end
			st_done: begin
				state_next = st_idle;
			end
			default: begin
				state_next = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= st_idle;
			mem_req <= 1'b0;
		end else begin
			state   <= state_next;
			// req is high for exactly the wait states, so it drops on the edge after ack
			mem_req <= (state_next == st_fill_wait) || (state_next == st_wr_wait);
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && valid) begin
			req_addr   <= addr;
			req_wren   <= wren;
			req_din    <= din;
			req_mask   <= mask;
			req_cached <= (addr < uncached_base);
		end
		if (state == st_lookup) begin
			hit_way_q  <= way_hit;
			from_mem_q <= !hit;
		end
		if (state == st_fill_wait && mem_ack) begin
			line_q <= mem_rdata;
		end
	end

	// reads fetch whole aligned lines, writes carry one aligned word
	assign mem_we    = req_wren;
	assign mem_addr  = req_wren ? {req_addr[31:3], 3'b000} : {req_addr[31:4], 4'b0000};
	assign mem_wdata = req_din;
	assign mem_wmask = req_mask;

	assign arr_index   = addr_index(req_addr);
	assign arr_tag     = addr_tag(req_addr);
	assign arr_fill    = (state == st_fill_wait) && mem_ack && req_cached;
	assign arr_wr      = (state == st_lookup) && req_wren && hit;
	assign arr_way     = (state == st_fill_wait) ? victim : way_hit;
	assign arr_line    = mem_rdata;
	assign arr_word    = req_din;
	assign arr_wr_hi   = req_addr[3];
	assign arr_wr_mask = req_mask;

	always_comb begin
		hit_line = rd_lines[0];
		for (int w = 0; w < num_ways; w++) begin
			if (hit_way_q[w]) begin
				hit_line = rd_lines[w];
			end
		end
	end

	// on a miss the fetched line is returned directly instead of reading it back
	assign line_sel = from_mem_q ? line_q : hit_line;
	assign dout     = req_addr[3] ? line_sel[127:64] : line_sel[63:0];
	assign ready    = (state == st_done);

	assert property (@(posedge clk) disable iff (rst) $fell(mem_req) |-> $past(mem_ack))
		else $error("mem_req dropped before the memory acknowledged");

	assert property (@(posedge clk) disable iff (rst) ready |=> !ready)
		else $error("ready held for more than one cycle");

endmodule

`default_nettype wire

// ==== hdl/dcache_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_data_array
	import dcache_pkg::*;
(
	input  wire logic     clk,
	input  wire index_t   index,
	input  wire logic     fill,
	input  wire logic     wr,
	input  wire way_t     way,
	input  wire line_t    fill_line,
	input  wire word_t    wr_word,
	input  wire logic     wr_hi,
	input  wire byte_en_t wr_mask,
	output line_t [3:0]   rd_lines
);

	line_t line_mem [num_ways][num_sets];

	// upper word of the line lives in bits 127:64
	logic [6:0] half_base;

	assign half_base = wr_hi ? 7'd64 : 7'd0;

	always_ff @(posedge clk) begin
		for (int w = 0; w < num_ways; w++) begin
			if (fill && way[w]) begin
				line_mem[w][index] <= fill_line;
			end else if (wr && way[w]) begin
				for (int b = 0; b < 8; b++) begin
					if (wr_mask[b]) begin
						line_mem[w][index][half_base + 7'(b * 8) +: 8] <= wr_word[b*8 +: 8];
					end
				end
			end
		end
	end

	// all four ways are read every cycle, the controller picks one later
	always_ff @(posedge clk) begin
		for (int w = 0; w < num_ways; w++) begin
			rd_lines[w] <= line_mem[w][index];
		end
	end

	// fills only happen on read misses and merges only on write hits
	assert property (@(posedge clk) !(fill && wr))
		else $error("line fill and word write requested in the same cycle");

endmodule

`default_nettype wire

// ==== hdl/dcache_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_array
	import dcache_pkg::*;
(
	input  wire logic   clk,
	input  wire logic   rst,
	input  wire index_t index,
	input  wire tag_t   tag,
	input  wire logic   fill,
	input  wire way_t   fill_way,
	output way_t        way_hit,
	output way_t        victim
);

	// one valid vector per way, one bit per set
	logic [num_sets-1:0] valid_q [num_ways];
	tag_t                tag_mem [num_ways][num_sets];

	// the round-robin pointer is shared by all sets and only used once every way of a set is valid
	logic [1:0] rr_ptr;

	way_t set_valid;
	logic set_full;

	always_comb begin
		for (int w = 0; w < num_ways; w++) begin
			set_valid[w] = valid_q[w][index];
			way_hit[w]   = valid_q[w][index] && (tag_mem[w][index] == tag);
		end
	end

	assign set_full = &set_valid;

	// walk down from the top way so the lowest invalid way wins
	always_comb begin
		victim = way_t'(1) << rr_ptr;
		for (int w = num_ways - 1; w >= 0; w--) begin
			if (!set_valid[w]) begin
				victim = way_t'(1) << w;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < num_ways; w++) begin
				valid_q[w] <= '0;
			end
			rr_ptr <= '0;
		end else if (fill) begin
			for (int w = 0; w < num_ways; w++) begin
				if (fill_way[w]) begin
					valid_q[w][index] <= 1'b1;
				end
			end
			// the pointer only moves when it actually picked the victim
			if (set_full) begin
				rr_ptr <= rr_ptr + 2'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill) begin
			for (int w = 0; w < num_ways; w++) begin
				if (fill_way[w]) begin
					tag_mem[w][index] <= tag;
				end
			end
		end
	end

	// a line is only ever filled into one way, so two ways never share a tag in one set
	assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit))
		else $error("tag array reports more than one hitting way");

endmodule

`default_nettype wire

// ==== hdl/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

	// the cache has four ways of 64 sets with 16-byte lines
	localparam int num_ways = 4;
	localparam int num_sets = 64;

	typedef logic [31:0]  addr_t;
	typedef logic [63:0]  word_t;
	typedef logic [127:0] line_t;
	typedef logic [7:0]   byte_en_t;
	typedef logic [21:0]  tag_t;
	typedef logic [5:0]   index_t;
	typedef logic [3:0]   way_t;

	typedef enum logic [2:0] {
		st_idle,
		st_lookup,
		st_fill_req,
		st_fill_wait,
		st_wr_req,
		st_wr_wait,
		st_done
	} ctrl_state_t;

	// tag is everything above the set index, bits 3:0 select the byte in the line
	function automatic tag_t addr_tag(input addr_t a);
		return a[31:10];
	endfunction

	function automatic index_t addr_index(input addr_t a);
		return a[9:4];
	endfunction

endpackage

`default_nettype wire
